// File: src/lpif_link_cfg.svh
`ifndef LPIF_LINK_CFG_SVH
`define LPIF_LINK_CFG_SVH

// Flit of one upstream or downstream channel beat
`define LPIF_FLIT_W 77

// Full PHY word on the die-to-die lane
`define LPIF_PHY_W 80

// Spare bit just above the flit, always driven low
`define LPIF_RSV_BIT 77

// Word alignment strobe position
`define LPIF_STB_BIT 78

// Word alignment marker position
`define LPIF_MRK_BIT 79

// Online and strobe delay counters
`define LPIF_DLY_W 16

`endif

// File: src/lpif_chan_pkg.sv
`default_nettype none

`include "lpif_link_cfg.svh"

package lpif_chan_pkg;

  //////////////////////////////
  // Channel fields
  //////////////////////////////

  // Link state as seen by the protocol layer
  typedef logic [3:0] chan_state_t;

  // Protocol id of the current beat
  typedef logic [1:0] chan_protid_t;

  // Payload of one beat
  typedef logic [63:0] chan_data_t;

  // CRC nibble
  typedef logic [3:0] chan_crc_t;

  //////////////////////////////
  // Flit
  //////////////////////////////

  // All channel fields packed into one vector, layout owned by the field mapper
  typedef logic [`LPIF_FLIT_W-1:0] flit_t;

endpackage

`default_nettype wire

// File: src/lpif_phy_pkg.sv
`default_nettype none

`include "lpif_link_cfg.svh"

package lpif_phy_pkg;

  // One word on the PHY lane, flit plus alignment bits
  typedef logic [`LPIF_PHY_W-1:0] phy_word_t;

  // Programmed delay and its counter
  typedef logic [`LPIF_DLY_W-1:0] dly_cnt_t;

  //////////////////////////////
  // Auto-sync FSM states
  //////////////////////////////

  // Transmit direction
  typedef enum logic [1:0] {
    TX_OFFLINE = 2'd0,
    TX_COUNT   = 2'd1,
    TX_ONLINE  = 2'd2
  } tx_sync_state_t;

  // Receive direction, only advances behind the transmit side
  typedef enum logic [1:0] {
    RX_OFFLINE = 2'd0,
    RX_COUNT   = 2'd1,
    RX_ONLINE  = 2'd2
  } rx_sync_state_t;

endpackage

`default_nettype wire

// File: src/ll_auto_sync.sv
`timescale 1ns/100ps
`default_nettype none

module ll_auto_sync #(
  parameter bit PERSISTENT_STROBE = 1'b1
) (
  input  logic                   clk_wr,
  input  logic                   reset,

  // Raw online levels
  input  logic                   tx_online,
  input  logic                   rx_online,

  // Alignment bit control
  input  logic                   m_gen2_mode,
  input  logic                   tx_mrk_userbit,
  input  logic                   tx_stb_userbit,

  // Programmed delays
  input  lpif_phy_pkg::dly_cnt_t delay_x_value,
  input  lpif_phy_pkg::dly_cnt_t delay_y_value,
  input  lpif_phy_pkg::dly_cnt_t delay_z_value,

  // Delayed online levels
  output logic                   tx_online_delay,
  output logic                   rx_online_delay,

  // Alignment bits towards the framer
  output logic                   tx_auto_stb_userbit,
  output logic                   tx_auto_mrk_userbit
);

  import lpif_phy_pkg::*;

  tx_sync_state_t tx_state;
  dly_cnt_t       tx_cnt;

  rx_sync_state_t rx_state;
  dly_cnt_t       rx_cnt;
  logic           rx_en;

  dly_cnt_t       stb_cnt;
  logic           stb_pulse;

  logic           mrk_tgl;

  //////////////////////////////
  // Transmit online delay
  //////////////////////////////

  // Count while tx_online holds, online once count reaches delay_x
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      tx_state <= TX_OFFLINE;
      tx_cnt   <= '0;
    end else begin
      case (tx_state)
        TX_OFFLINE, TX_COUNT: begin
          if (tx_cnt >= delay_x_value) begin
            tx_state <= TX_ONLINE;
          end else begin
            tx_state <= TX_COUNT;
            tx_cnt   <= tx_cnt + 1'b1;
          end
        end
        default: tx_state <= TX_ONLINE;
      endcase
    end
  end

  assign tx_online_delay = (tx_state == TX_ONLINE);

  //////////////////////////////
  // Receive online delay
  //////////////////////////////

  // Raw tx_online too, so rx drops on the same edge as tx
  assign rx_en = rx_online && tx_online_delay && tx_online;

  always_ff @(posedge clk_wr) begin
    if (reset || !rx_en) begin
      rx_state <= RX_OFFLINE;
      rx_cnt   <= '0;
    end else begin
      case (rx_state)
        RX_OFFLINE, RX_COUNT: begin
          if (rx_cnt >= delay_y_value) begin
            rx_state <= RX_ONLINE;
          end else begin
            rx_state <= RX_COUNT;
            rx_cnt   <= rx_cnt + 1'b1;
          end
        end
        default: rx_state <= RX_ONLINE;
      endcase
    end
  end

  assign rx_online_delay = (rx_state == RX_ONLINE);

  //////////////////////////////
  // Strobe
  //////////////////////////////

  // Period of delay_z+1, first pulse right after tx_online is seen
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      stb_cnt   <= '0;
      stb_pulse <= 1'b0;
    end else begin
      stb_pulse <= (stb_cnt == '0) && (PERSISTENT_STROBE || !tx_online_delay);
      if (stb_cnt >= delay_z_value) begin
        stb_cnt <= '0;
      end else begin
        stb_cnt <= stb_cnt + 1'b1;
      end
    end
  end

  // User strobe can still be forced on top
  assign tx_auto_stb_userbit = stb_pulse | tx_stb_userbit;

  //////////////////////////////
  // Marker
  //////////////////////////////

  // Gen2 alternates words, gen1 uses the user marker as is
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online || !m_gen2_mode) begin
      mrk_tgl <= 1'b0;
    end else begin
      mrk_tgl <= !mrk_tgl;
    end
  end

  assign tx_auto_mrk_userbit = (tx_online && m_gen2_mode) ? mrk_tgl : tx_mrk_userbit;

  // Receive side may only be online behind the transmit side
  a_rx_behind_tx: assert property (@(posedge clk_wr) !tx_online_delay |-> !rx_online_delay);

  // No generated pulse in the cycle after reset
  a_stb_reset: assert property (
    @(posedge clk_wr) reset |=> (tx_auto_stb_userbit == tx_stb_userbit)
  );

endmodule

`default_nettype wire

// File: src/lpif_slave_name.sv
`timescale 1ns/100ps
`default_nettype none

module lpif_slave_name (
  // Upstream channel from the protocol layer
  input  lpif_chan_pkg::chan_state_t  ustrm_state,
  input  lpif_chan_pkg::chan_protid_t ustrm_protid,
  input  lpif_chan_pkg::chan_data_t   ustrm_data,
  input  logic                        ustrm_dvalid,
  input  lpif_chan_pkg::chan_crc_t    ustrm_crc,
  input  logic                        ustrm_crc_valid,
  input  logic                        ustrm_valid,

  // Received flit from the framer
  input  lpif_chan_pkg::flit_t        rxfifo_downstream_data,

  // Downstream channel to the protocol layer
  output lpif_chan_pkg::chan_state_t  dstrm_state,
  output lpif_chan_pkg::chan_protid_t dstrm_protid,
  output lpif_chan_pkg::chan_data_t   dstrm_data,
  output logic                        dstrm_dvalid,
  output lpif_chan_pkg::chan_crc_t    dstrm_crc,
  output logic                        dstrm_crc_valid,
  output logic                        dstrm_valid,

  // Flit to transmit
  output lpif_chan_pkg::flit_t        txfifo_upstream_data
);

  //////////////////////////////
  // Flit layout, LSB upward
  //////////////////////////////

  localparam int DATA_LSB   = 0;
  localparam int STATE_LSB  = 64;
  localparam int PROTID_LSB = 68;
  localparam int CRC_LSB    = 70;
  localparam int DVALID_BIT = 74;
  localparam int CRCV_BIT   = 75;
  localparam int VALID_BIT  = 76;

  // Upstream fields into the flit
  assign txfifo_upstream_data[DATA_LSB   +: 64] = ustrm_data;
  assign txfifo_upstream_data[STATE_LSB  +:  4] = ustrm_state;
  assign txfifo_upstream_data[PROTID_LSB +:  2] = ustrm_protid;
  assign txfifo_upstream_data[CRC_LSB    +:  4] = ustrm_crc;
  assign txfifo_upstream_data[DVALID_BIT]       = ustrm_dvalid;
  assign txfifo_upstream_data[CRCV_BIT]         = ustrm_crc_valid;
  assign txfifo_upstream_data[VALID_BIT]        = ustrm_valid;

  // Received flit back into downstream fields
  assign dstrm_data      = rxfifo_downstream_data[DATA_LSB   +: 64];
  assign dstrm_state     = rxfifo_downstream_data[STATE_LSB  +:  4];
  assign dstrm_protid    = rxfifo_downstream_data[PROTID_LSB +:  2];
  assign dstrm_crc       = rxfifo_downstream_data[CRC_LSB    +:  4];
  assign dstrm_dvalid    = rxfifo_downstream_data[DVALID_BIT];
  assign dstrm_crc_valid = rxfifo_downstream_data[CRCV_BIT];
  assign dstrm_valid     = rxfifo_downstream_data[VALID_BIT];

endmodule

`default_nettype wire

// File: src/lpif_slave_concat.sv
`timescale 1ns/100ps
`default_nettype none

`include "lpif_link_cfg.svh"

module lpif_slave_concat (
  input  logic                     clk_wr,
  input  logic                     reset,

  // Delayed online levels from auto sync
  input  logic                     tx_online_delay,
  input  logic                     rx_online_delay,

  // Alignment bits already sequenced by auto sync
  input  logic                     tx_stb_userbit,
  input  logic                     tx_mrk_userbit,

  // Flit to send
  input  lpif_chan_pkg::flit_t     tx_upstream_data,

  // PHY lane
  input  lpif_phy_pkg::phy_word_t  rx_phy0,
  output lpif_phy_pkg::phy_word_t  tx_phy0,

  // Decoded receive flit
  output lpif_chan_pkg::flit_t     rx_downstream_data
);

  import lpif_chan_pkg::*;

  flit_t tx_flit_q;
  logic  tx_stb_q;
  logic  tx_mrk_q;

  flit_t rx_flit_q;

  //////////////////////////////
  // Transmit framing
  //////////////////////////////

  // Payload stage
  always_ff @(posedge clk_wr) begin
    tx_flit_q <= tx_upstream_data;
  end

  // Alignment bits in the same stage as the payload
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_stb_q <= 1'b0;
      tx_mrk_q <= 1'b0;
    end else begin
      tx_stb_q <= tx_stb_userbit;
      tx_mrk_q <= tx_mrk_userbit;
    end
  end

  // Flit bits idle low until the transmit side is online
  always_comb begin
    tx_phy0                     = '0;
    tx_phy0[`LPIF_FLIT_W-1:0]   = tx_online_delay ? tx_flit_q : '0;
    tx_phy0[`LPIF_STB_BIT]      = tx_stb_q;
    tx_phy0[`LPIF_MRK_BIT]      = tx_mrk_q;
  end

  //////////////////////////////
  // Receive decode
  //////////////////////////////

  // Capture flit portion of the lane word
  always_ff @(posedge clk_wr) begin
    rx_flit_q <= rx_phy0[`LPIF_FLIT_W-1:0];
  end

  // Nothing reaches the channel while receive is offline
  assign rx_downstream_data = rx_online_delay ? rx_flit_q : '0;

  // Spare lane bit never carries anything
  a_rsv_zero: assert property (@(posedge clk_wr) tx_phy0[`LPIF_RSV_BIT] == 1'b0);

endmodule

`default_nettype wire

// File: src/lpif_slave_top.sv
`timescale 1ns/100ps
`default_nettype none

module lpif_slave_top (
  input  logic                        clk_wr,
  input  logic                        reset,

  // Online control
  input  logic                        tx_online,
  input  logic                        rx_online,

  // PHY lane
  output lpif_phy_pkg::phy_word_t     tx_phy0,
  input  lpif_phy_pkg::phy_word_t     rx_phy0,

  // Downstream channel
  output lpif_chan_pkg::chan_state_t  dstrm_state,
  output lpif_chan_pkg::chan_protid_t dstrm_protid,
  output lpif_chan_pkg::chan_data_t   dstrm_data,
  output logic                        dstrm_dvalid,
  output lpif_chan_pkg::chan_crc_t    dstrm_crc,
  output logic                        dstrm_crc_valid,
  output logic                        dstrm_valid,

  // Upstream channel
  input  lpif_chan_pkg::chan_state_t  ustrm_state,
  input  lpif_chan_pkg::chan_protid_t ustrm_protid,
  input  lpif_chan_pkg::chan_data_t   ustrm_data,
  input  logic                        ustrm_dvalid,
  input  lpif_chan_pkg::chan_crc_t    ustrm_crc,
  input  logic                        ustrm_crc_valid,
  input  logic                        ustrm_valid,

  // Debug status
  output logic [31:0]                 rx_downstream_debug_status,
  output logic [31:0]                 tx_upstream_debug_status,

  // Configuration
  input  logic                        m_gen2_mode,
  input  logic                        tx_mrk_userbit,
  input  logic                        tx_stb_userbit,
  input  lpif_phy_pkg::dly_cnt_t      delay_x_value,
  input  lpif_phy_pkg::dly_cnt_t      delay_y_value,
  input  lpif_phy_pkg::dly_cnt_t      delay_z_value
);

  import lpif_chan_pkg::*;

  flit_t       txfifo_upstream_data;
  flit_t       rx_downstream_data;

  logic        tx_online_delay;
  logic        rx_online_delay;
  logic        tx_auto_stb_userbit;
  logic        tx_auto_mrk_userbit;

  logic [31:0] link_status;

  //////////////////////////////
  // Online sequencing
  //////////////////////////////

  ll_auto_sync #(
    .PERSISTENT_STROBE (1'b1)
  ) u_ll_auto_sync (
    .clk_wr              (clk_wr),
    .reset               (reset),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .m_gen2_mode         (m_gen2_mode),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  //////////////////////////////
  // Channel field mapping
  //////////////////////////////

  lpif_slave_name u_lpif_slave_name (
    .ustrm_state            (ustrm_state),
    .ustrm_protid           (ustrm_protid),
    .ustrm_data             (ustrm_data),
    .ustrm_dvalid           (ustrm_dvalid),
    .ustrm_crc              (ustrm_crc),
    .ustrm_crc_valid        (ustrm_crc_valid),
    .ustrm_valid            (ustrm_valid),
    .rxfifo_downstream_data (rx_downstream_data),
    .dstrm_state            (dstrm_state),
    .dstrm_protid           (dstrm_protid),
    .dstrm_data             (dstrm_data),
    .dstrm_dvalid           (dstrm_dvalid),
    .dstrm_crc              (dstrm_crc),
    .dstrm_crc_valid        (dstrm_crc_valid),
    .dstrm_valid            (dstrm_valid),
    .txfifo_upstream_data   (txfifo_upstream_data)
  );

  //////////////////////////////
  // PHY framing
  //////////////////////////////

  lpif_slave_concat u_lpif_slave_concat (
    .clk_wr             (clk_wr),
    .reset              (reset),
    .tx_online_delay    (tx_online_delay),
    .rx_online_delay    (rx_online_delay),
    .tx_stb_userbit     (tx_auto_stb_userbit),
    .tx_mrk_userbit     (tx_auto_mrk_userbit),
    .tx_upstream_data   (txfifo_upstream_data),
    .rx_phy0            (rx_phy0),
    .tx_phy0            (tx_phy0),
    .rx_downstream_data (rx_downstream_data)
  );

  // Online levels at bits 19 and 18, rest unused
  assign link_status = {12'h000, tx_online_delay, rx_online_delay, 18'h00000};

  // Same view on both debug ports
  assign rx_downstream_debug_status = link_status;
  assign tx_upstream_debug_status   = link_status;

endmodule

`default_nettype wire

// File: verification/lpif_slave_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lpif_link_cfg.svh"

module lpif_slave_tb;

  import lpif_chan_pkg::*;
  import lpif_phy_pkg::*;

  // Cycles per test, one extra per test for the closing check
  localparam int LEN_ALL     = 18 + 36 + 62 + 62 + 82 + 5;
  localparam int CYCLE_LIMIT = LEN_ALL + 40;

  logic         clk_wr;
  logic         reset;
  logic         tx_online;
  logic         rx_online;
  phy_word_t    tx_phy0;
  phy_word_t    rx_phy0;
  chan_state_t  dstrm_state;
  chan_protid_t dstrm_protid;
  chan_data_t   dstrm_data;
  logic         dstrm_dvalid;
  chan_crc_t    dstrm_crc;
  logic         dstrm_crc_valid;
  logic         dstrm_valid;
  chan_state_t  ustrm_state;
  chan_protid_t ustrm_protid;
  chan_data_t   ustrm_data;
  logic         ustrm_dvalid;
  chan_crc_t    ustrm_crc;
  logic         ustrm_crc_valid;
  logic         ustrm_valid;
  logic [31:0]  rx_downstream_debug_status;
  logic [31:0]  tx_upstream_debug_status;
  logic         m_gen2_mode;
  logic         tx_mrk_userbit;
  logic         tx_stb_userbit;
  dly_cnt_t     delay_x_value;
  dly_cnt_t     delay_y_value;
  dly_cnt_t     delay_z_value;

  // Run bookkeeping
  logic [31:0]  seed;
  string        test_name;
  int           err_cnt;
  int           errs_at_start;
  int           tests_run;
  int           tests_failed;
  int           cycle_cnt;
  logic         check_en;
  logic         mrk_random;

  // Reference model state
  int           tx_run;
  int           rx_run;
  int           gen2_run;
  logic         exp_pulse;
  logic         exp_stb_bit;
  logic         exp_mrk_bit;
  flit_t        exp_flit;
  flit_t        exp_rx_flit;
  logic         exp_tx_on;
  logic         exp_rx_on;
  flit_t        exp_tx_flit;
  flit_t        exp_dstrm;
  logic [31:0]  exp_debug;
  flit_t        dstrm_flit;

  lpif_slave_top u_lpif_slave_top (.*);

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  // Flit layout, LSB upward
  function automatic flit_t pack_flit(input chan_state_t state, input chan_protid_t protid,
                                      input chan_data_t data, input logic dvalid,
                                      input chan_crc_t crc, input logic crc_valid,
                                      input logic valid);
    return {valid, crc_valid, dvalid, crc, protid, state, data};
  endfunction

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic log_mismatch(input string what, input logic [79:0] exp_val,
                              input logic [79:0] act_val);
    err_cnt++;
    $display("ERR %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
  endtask

  // One cycle per call, fresh random traffic on both lanes
  task automatic step(input int n);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    int          i;
    for (i = 0; i < n; i++) begin
      @(posedge clk_wr);
      r0 = next_rand();
      r1 = next_rand();
      r2 = next_rand();
      ustrm_data      <= {r0, r1};
      ustrm_state     <= r2[19:16];
      ustrm_protid    <= r2[21:20];
      ustrm_crc       <= r2[25:22];
      ustrm_dvalid    <= r2[26];
      ustrm_crc_valid <= r2[27];
      ustrm_valid     <= r2[28];
      tx_mrk_userbit  <= mrk_random & r2[29];
      rx_phy0         <= {r2[15:0], r1, r0};
    end
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    errs_at_start = err_cnt;
  endtask

  // Let the last negedge check land, then report and realign on a rising edge
  task automatic end_test();
    @(negedge clk_wr);
    #1;
    tests_run++;
    if (err_cnt == errs_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL, %0d mismatches", test_name, err_cnt - errs_at_start);
    end
    @(posedge clk_wr);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Runs count consecutive edges with the enabling inputs high
  always @(posedge clk_wr) begin
    if (reset) begin
      tx_run      <= 0;
      rx_run      <= 0;
      gen2_run    <= 0;
      exp_pulse   <= 1'b0;
      exp_stb_bit <= 1'b0;
      exp_mrk_bit <= 1'b0;
    end else begin
      tx_run      <= tx_online ? tx_run + 1 : 0;
      rx_run      <= (rx_online && tx_online && exp_tx_on) ? rx_run + 1 : 0;
      gen2_run    <= (tx_online && m_gen2_mode) ? gen2_run + 1 : 0;
      // First pulse on the first online edge, then every z+1
      exp_pulse   <= tx_online && ((tx_run % (int'(delay_z_value) + 1)) == 0);
      exp_stb_bit <= exp_pulse | tx_stb_userbit;
      exp_mrk_bit <= (tx_online && m_gen2_mode) ? gen2_run[0] : tx_mrk_userbit;
    end
    exp_flit <= pack_flit(ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                          ustrm_crc, ustrm_crc_valid, ustrm_valid);
    exp_rx_flit <= rx_phy0[`LPIF_FLIT_W-1:0];
  end

  assign exp_tx_on   = tx_run > int'(delay_x_value);
  assign exp_rx_on   = rx_run > int'(delay_y_value);
  assign exp_tx_flit = exp_tx_on ? exp_flit : '0;
  assign exp_dstrm   = exp_rx_on ? exp_rx_flit : '0;
  assign exp_debug   = {12'h000, exp_tx_on, exp_rx_on, 18'h00000};
  assign dstrm_flit  = pack_flit(dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                                 dstrm_crc, dstrm_crc_valid, dstrm_valid);

  //////////////////////////////
  // Checks, on the falling edge
  //////////////////////////////

  a_tx_flit: assert property (@(negedge clk_wr) disable iff (!check_en)
    tx_phy0[`LPIF_FLIT_W-1:0] === exp_tx_flit)
    else log_mismatch("tx flit", exp_tx_flit, tx_phy0[`LPIF_FLIT_W-1:0]);
  a_rsv_bit: assert property (@(negedge clk_wr) disable iff (!check_en)
    tx_phy0[`LPIF_RSV_BIT] === 1'b0)
    else log_mismatch("reserved bit", 80'd0, tx_phy0[`LPIF_RSV_BIT]);
  a_strobe: assert property (@(negedge clk_wr) disable iff (!check_en)
    tx_phy0[`LPIF_STB_BIT] === exp_stb_bit)
    else log_mismatch("strobe", exp_stb_bit, tx_phy0[`LPIF_STB_BIT]);
  a_marker: assert property (@(negedge clk_wr) disable iff (!check_en)
    tx_phy0[`LPIF_MRK_BIT] === exp_mrk_bit)
    else log_mismatch("marker", exp_mrk_bit, tx_phy0[`LPIF_MRK_BIT]);
  a_dstrm: assert property (@(negedge clk_wr) disable iff (!check_en)
    dstrm_flit === exp_dstrm)
    else log_mismatch("dstrm", exp_dstrm, dstrm_flit);
  a_rx_debug: assert property (@(negedge clk_wr) disable iff (!check_en)
    rx_downstream_debug_status === exp_debug)
    else log_mismatch("rx debug", exp_debug, rx_downstream_debug_status);
  a_tx_debug: assert property (@(negedge clk_wr) disable iff (!check_en)
    tx_upstream_debug_status === exp_debug)
    else log_mismatch("tx debug", exp_debug, tx_upstream_debug_status);

  // Hang guard
  always @(posedge clk_wr) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    seed            = 32'hdffc;
    err_cnt         = 0;
    errs_at_start   = 0;
    tests_run       = 0;
    tests_failed    = 0;
    cycle_cnt       = 0;
    check_en        = 1'b0;
    mrk_random      = 1'b0;
    reset           = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    rx_phy0         = '0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    m_gen2_mode     = 1'b0;
    tx_mrk_userbit  = 1'b0;
    tx_stb_userbit  = 1'b0;
    delay_x_value   = 16'd5;
    delay_y_value   = 16'd3;
    delay_z_value   = 16'd4;

    // Reset, checks armed once the first edge has cleared the registers
    begin_test("reset");
    step(2);
    check_en <= 1'b1;
    step(8);
    reset <= 1'b0;
    step(8);
    end_test();

    // Both online levels rise, then drop one after the other
    begin_test("online_delay");
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    step(20);
    rx_online <= 1'b0;
    step(4);
    rx_online <= 1'b1;
    step(8);
    tx_online <= 1'b0;
    step(4);
    end_test();

    // Short x delay, long run of random upstream flits
    begin_test("tx_framing");
    delay_x_value <= 16'd2;
    step(2);
    tx_online <= 1'b1;
    step(60);
    end_test();

    // Receive gate opens, closes and opens again
    begin_test("rx_decode");
    rx_online     <= 1'b0;
    delay_y_value <= 16'd1;
    step(2);
    rx_online <= 1'b1;
    step(30);
    rx_online <= 1'b0;
    step(5);
    rx_online <= 1'b1;
    step(25);
    end_test();

    // Gen2 toggling first, then gen1 with a random user marker
    begin_test("strobe_marker");
    tx_online     <= 1'b0;
    rx_online     <= 1'b0;
    delay_z_value <= 16'd6;
    m_gen2_mode   <= 1'b1;
    step(2);
    tx_online <= 1'b1;
    step(40);
    m_gen2_mode <= 1'b0;
    mrk_random  <= 1'b1;
    step(40);
    end_test();

    $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/lpif_chan_pkg.sv
src/lpif_phy_pkg.sv
src/ll_auto_sync.sv
src/lpif_slave_name.sv
src/lpif_slave_concat.sv
src/lpif_slave_top.sv
verification/lpif_slave_tb.sv
